/* cdb_pkg.sv */
`default_nettype none

package cdb_pkg;

	// data and address width
	localparam int WORD_SIZE = 16;

	// unit numbering, ALUs first and then the store units
	localparam int ALU_NUM = 2;
	localparam int STORER_NUM = 1;
	localparam int FU_NUM = ALU_NUM + STORER_NUM;
	localparam int STORER_START = ALU_NUM;

	// unit number carried with each issue, FU_NONE selects nothing
	typedef enum logic [1:0] {
		FU_ALU0 = 2'd0,
		FU_ALU1 = 2'd1,
		FU_STORE = 2'd2,
		FU_NONE = 2'd3
	} fu_sel_t;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_XOR = 2'd3
	} alu_op_t;

	typedef struct packed {
		alu_op_t op;
		logic [WORD_SIZE-1:0] a;
		logic [WORD_SIZE-1:0] b;
	} alu_view_t;

	typedef struct packed {
		logic [1:0] unused;
		logic [WORD_SIZE-1:0] base;
		logic [WORD_SIZE-1:0] offset;
	} store_view_t;

	// one 34-bit issue word, read by the ALUs or by the store unit
	typedef union packed {
		alu_view_t alu;
		store_view_t store;
	} issue_word_u;

endpackage

`default_nettype wire

/* cdb_result_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cdb_result_if #(
	parameter int ROB_DEPTH = 8
);
	import cdb_pkg::*;

	localparam int TAG_W = $clog2(ROB_DEPTH);

	// one-cycle pulse per finished instruction
	logic valid;
	// ROB slot the result belongs to
	logic [TAG_W-1:0] tag;
	logic [WORD_SIZE-1:0] data;
	// only the store unit drives a real address
	logic [WORD_SIZE-1:0] addr;
	logic is_store;

	modport producer (
		output valid,
		output tag,
		output data,
		output addr,
		output is_store
	);

	modport consumer (
		input valid,
		input tag,
		input data,
		input addr,
		input is_store
	);

endinterface

`default_nettype wire

/* issue_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch #(
	parameter int ROB_DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input cdb_pkg::fu_sel_t issue_unit,
	input cdb_pkg::issue_word_u issue_word,
	input logic alloc_ready,
	input logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
	output logic alloc,
	output logic alloc_is_store,
	output logic [cdb_pkg::FU_NUM-1:0] start,
	output logic [$clog2(ROB_DEPTH)-1:0] start_tag,
	output cdb_pkg::issue_word_u start_word
);
	import cdb_pkg::*;

	logic unit_ok;
	logic accept;

	// unit 3 names no unit and never takes a ROB slot
	assign unit_ok = (issue_unit != FU_NONE);
	// a full ROB drops the issue, nothing is queued here
	assign accept = issue_valid && alloc_ready && unit_ok;

	assign alloc = accept;
	assign alloc_is_store = (issue_unit == FU_STORE);

	// one-hot start towards the selected unit
	always_comb begin
		start = '0;
		if (accept) begin
			start[issue_unit] = 1'b1;
		end
	end

	// the unit gets the tag the ROB hands out in this same cycle
	assign start_tag = alloc_tag;
	assign start_word = issue_word;

	// every start is paired with an allocation, and at most one unit starts
	a_start_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(start) && (alloc == (|start)));

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
	parameter int ROB_DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [$clog2(ROB_DEPTH)-1:0] tag,
	input cdb_pkg::issue_word_u word,
	cdb_result_if.producer cdb
);
	import cdb_pkg::*;

	logic [WORD_SIZE-1:0] result;

	// all results wrap at 16 bits
	always_comb begin
		case (word.alu.op)
			ALU_ADD: result = word.alu.a + word.alu.b;
			ALU_SUB: result = word.alu.a - word.alu.b;
			ALU_AND: result = word.alu.a & word.alu.b;
			ALU_XOR: result = word.alu.a ^ word.alu.b;
			default: result = '0;
		endcase
	end

	// broadcast valid one cycle after start
	always_ff @(posedge clk) begin
		if (reset) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= start;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cdb.tag <= tag;
			cdb.data <= result;
		end
	end

	// ALU results carry no address
	assign cdb.addr = '0;
	assign cdb.is_store = 1'b0;

endmodule

`default_nettype wire

/* store_agu.sv */
`timescale 1ns/1ps
`default_nettype none

module store_agu #(
	parameter int ROB_DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [$clog2(ROB_DEPTH)-1:0] tag,
	input cdb_pkg::issue_word_u word,
	input logic [15:0] store_data,
	cdb_result_if.producer cdb
);
	import cdb_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= start;
		end
	end

	// address wraps at 16 bits
	always_ff @(posedge clk) begin
		if (start) begin
			cdb.tag <= tag;
			cdb.addr <= word.store.base + word.store.offset;
			cdb.data <= store_data;
		end
	end

	assign cdb.is_store = 1'b1;

endmodule

`default_nettype wire

/* cdb_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_writeback #(
	parameter int ROB_DEPTH = 8
) (
	input logic clk,
	input logic reset,
	cdb_result_if.consumer cdb_alu0,
	cdb_result_if.consumer cdb_alu1,
	cdb_result_if.consumer cdb_store,
	output logic [ROB_DEPTH-1:0] wr_en,
	output logic [ROB_DEPTH*cdb_pkg::WORD_SIZE-1:0] wr_data,
	output logic [ROB_DEPTH*cdb_pkg::WORD_SIZE-1:0] wr_addr,
	output logic [ROB_DEPTH-1:0] wr_is_store
);
	import cdb_pkg::*;

	localparam int TAG_W = $clog2(ROB_DEPTH);

	logic [FU_NUM-1:0] fu_valid;
	logic [TAG_W-1:0] fu_tag [FU_NUM];
	logic [WORD_SIZE-1:0] fu_data [FU_NUM];
	logic [WORD_SIZE-1:0] fu_addr [FU_NUM];
	logic [FU_NUM-1:0] fu_is_store;

	logic [ROB_DEPTH-1:0] en_next;
	logic [ROB_DEPTH*WORD_SIZE-1:0] data_next;
	logic [ROB_DEPTH*WORD_SIZE-1:0] addr_next;
	logic [ROB_DEPTH-1:0] st_next;

	// unit buses in unit-number order
	always_comb begin
		fu_valid[0] = cdb_alu0.valid;
		fu_tag[0] = cdb_alu0.tag;
		fu_data[0] = cdb_alu0.data;
		fu_addr[0] = cdb_alu0.addr;
		fu_is_store[0] = cdb_alu0.is_store;
		fu_valid[1] = cdb_alu1.valid;
		fu_tag[1] = cdb_alu1.tag;
		fu_data[1] = cdb_alu1.data;
		fu_addr[1] = cdb_alu1.addr;
		fu_is_store[1] = cdb_alu1.is_store;
		fu_valid[STORER_START] = cdb_store.valid;
		fu_tag[STORER_START] = cdb_store.tag;
		fu_data[STORER_START] = cdb_store.data;
		fu_addr[STORER_START] = cdb_store.addr;
		fu_is_store[STORER_START] = cdb_store.is_store;
	end

	// walk the units and merge each broadcast into the slot its tag names
	always_comb begin
		en_next = '0;
		data_next = wr_data;
		addr_next = wr_addr;
		st_next = wr_is_store;
		for (int i = 0; i < FU_NUM; i++) begin
			if (fu_valid[i]) begin
				en_next[fu_tag[i]] = 1'b1;
				data_next[fu_tag[i]*WORD_SIZE +: WORD_SIZE] = fu_data[i];
				addr_next[fu_tag[i]*WORD_SIZE +: WORD_SIZE] = fu_addr[i];
				st_next[fu_tag[i]] = fu_is_store[i];
			end
		end
	end

	// write strobes are single-cycle pulses
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_en <= '0;
		end else begin
			wr_en <= en_next;
		end
	end

	always_ff @(posedge clk) begin
		wr_data <= data_next;
		wr_addr <= addr_next;
		wr_is_store <= st_next;
	end

	// tags are handed out once per slot, so no two units finish on one slot
	for (genvar i = 0; i < FU_NUM; i++) begin : g_clash_i
		for (genvar j = i + 1; j < FU_NUM; j++) begin : g_clash_j
			a_unique_tag: assert property (@(posedge clk) disable iff (reset)
				!(fu_valid[i] && fu_valid[j] && (fu_tag[i] == fu_tag[j])));
		end
	end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
	parameter int ROB_DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic alloc,
	input logic alloc_is_store,
	output logic alloc_ready,
	output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
	input logic [ROB_DEPTH-1:0] wr_en,
	input logic [ROB_DEPTH*cdb_pkg::WORD_SIZE-1:0] wr_data,
	input logic [ROB_DEPTH*cdb_pkg::WORD_SIZE-1:0] wr_addr,
	input logic [ROB_DEPTH-1:0] wr_is_store,
	output logic commit_valid,
	output logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
	output logic [cdb_pkg::WORD_SIZE-1:0] commit_data,
	output logic [cdb_pkg::WORD_SIZE-1:0] commit_addr,
	output logic commit_is_store
);
	import cdb_pkg::*;

	localparam int TAG_W = $clog2(ROB_DEPTH);

	logic [TAG_W-1:0] head;
	logic [TAG_W-1:0] tail;
	// one extra bit to tell full from empty
	logic [TAG_W:0] count;

	logic [ROB_DEPTH-1:0] busy;
	logic [ROB_DEPTH-1:0] done;
	logic [ROB_DEPTH-1:0] is_store;
	logic [WORD_SIZE-1:0] data_q [ROB_DEPTH];
	logic [WORD_SIZE-1:0] addr_q [ROB_DEPTH];

	assign alloc_ready = (count < ROB_DEPTH);
	assign alloc_tag = tail;

	// head retires as soon as its result is in
	assign commit_valid = busy[head] && done[head];
	assign commit_tag = head;
	assign commit_data = data_q[head];
	assign commit_addr = addr_q[head];
	assign commit_is_store = is_store[head];

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			busy <= '0;
			done <= '0;
		end else begin
			for (int s = 0; s < ROB_DEPTH; s++) begin
				if (wr_en[s]) begin
					done[s] <= 1'b1;
				end
			end
			if (alloc) begin
				busy[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (commit_valid) begin
				busy[head] <= 1'b0;
				done[head] <= 1'b0;
				head <= head + 1'b1;
			end
			case ({alloc, commit_valid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// kind of entry is known at allocation, the write confirms it
	always_ff @(posedge clk) begin
		if (alloc) begin
			is_store[tail] <= alloc_is_store;
		end
		for (int s = 0; s < ROB_DEPTH; s++) begin
			if (wr_en[s]) begin
				data_q[s] <= wr_data[s*WORD_SIZE +: WORD_SIZE];
				addr_q[s] <= wr_addr[s*WORD_SIZE +: WORD_SIZE];
				is_store[s] <= wr_is_store[s];
			end
		end
	end

	// writeback only ever lands on a slot that is still outstanding
	a_write_busy: assert property (@(posedge clk) disable iff (reset)
		(wr_en & ~busy) == '0);

	// the unit's store flag agrees with the kind recorded at allocation
	a_kind_match: assert property (@(posedge clk) disable iff (reset)
		(wr_en & (wr_is_store ^ is_store)) == '0);

endmodule

`default_nettype wire

/* ooo_commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_commit_top #(
	parameter int ROB_DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input cdb_pkg::fu_sel_t issue_unit,
	input cdb_pkg::issue_word_u issue_word,
	input logic [cdb_pkg::WORD_SIZE-1:0] issue_store_data,
	output logic issue_ready,
	output logic [$clog2(ROB_DEPTH)-1:0] issue_tag,
	output logic commit_valid,
	output logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
	output logic [cdb_pkg::WORD_SIZE-1:0] commit_data,
	output logic [cdb_pkg::WORD_SIZE-1:0] commit_addr,
	output logic commit_is_store
);
	import cdb_pkg::*;

	localparam int TAG_W = $clog2(ROB_DEPTH);

	logic alloc;
	logic alloc_is_store;
	logic [FU_NUM-1:0] start;
	logic [TAG_W-1:0] start_tag;
	issue_word_u start_word;
	logic [ROB_DEPTH-1:0] wr_en;
	logic [ROB_DEPTH-1:0] wr_is_store;
	logic [ROB_DEPTH*WORD_SIZE-1:0] wr_data;
	logic [ROB_DEPTH*WORD_SIZE-1:0] wr_addr;

	cdb_result_if #(.ROB_DEPTH(ROB_DEPTH)) cdb_alu0 ();
	cdb_result_if #(.ROB_DEPTH(ROB_DEPTH)) cdb_alu1 ();
	cdb_result_if #(.ROB_DEPTH(ROB_DEPTH)) cdb_store ();

	// issue_ready and issue_tag come straight from the ROB allocator
	issue_dispatch #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_unit(issue_unit),
		.issue_word(issue_word), .alloc_ready(issue_ready), .alloc_tag(issue_tag),
		.alloc(alloc), .alloc_is_store(alloc_is_store), .start(start),
		.start_tag(start_tag), .start_word(start_word)
	);

	alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu0 (
		.clk(clk), .reset(reset), .start(start[0]), .tag(start_tag),
		.word(start_word), .cdb(cdb_alu0.producer)
	);

	alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu1 (
		.clk(clk), .reset(reset), .start(start[1]), .tag(start_tag),
		.word(start_word), .cdb(cdb_alu1.producer)
	);

	store_agu #(.ROB_DEPTH(ROB_DEPTH)) u_store (
		.clk(clk), .reset(reset), .start(start[STORER_START]), .tag(start_tag),
		.word(start_word), .store_data(issue_store_data), .cdb(cdb_store.producer)
	);

	cdb_writeback #(.ROB_DEPTH(ROB_DEPTH)) u_writeback (
		.clk(clk), .reset(reset), .cdb_alu0(cdb_alu0.consumer),
		.cdb_alu1(cdb_alu1.consumer), .cdb_store(cdb_store.consumer),
		.wr_en(wr_en), .wr_data(wr_data), .wr_addr(wr_addr), .wr_is_store(wr_is_store)
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
		.clk(clk), .reset(reset), .alloc(alloc), .alloc_is_store(alloc_is_store),
		.alloc_ready(issue_ready), .alloc_tag(issue_tag), .wr_en(wr_en),
		.wr_data(wr_data), .wr_addr(wr_addr), .wr_is_store(wr_is_store),
		.commit_valid(commit_valid), .commit_tag(commit_tag), .commit_data(commit_data),
		.commit_addr(commit_addr), .commit_is_store(commit_is_store)
	);

endmodule

`default_nettype wire

/* tb_ooo_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_commit;
	import cdb_pkg::*;

	localparam int ROB_DEPTH = 8;
	localparam int TAG_W = $clog2(ROB_DEPTH);
	// issues per test, in test order
	localparam int ISSUES_TOTAL = 8 + 4 + 68 + 9 + 3 + 8;
	localparam int TIMEOUT_CYCLES = ISSUES_TOTAL * 20;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [WORD_SIZE-1:0] data;
		logic [WORD_SIZE-1:0] addr;
		logic is_store;
	} expect_t;

	logic clk;
	logic reset;
	logic issue_valid;
	fu_sel_t issue_unit;
	issue_word_u issue_word;
	logic [WORD_SIZE-1:0] issue_store_data;
	logic issue_ready;
	logic [TAG_W-1:0] issue_tag;
	logic commit_valid;
	logic [TAG_W-1:0] commit_tag;
	logic [WORD_SIZE-1:0] commit_data;
	logic [WORD_SIZE-1:0] commit_addr;
	logic commit_is_store;

	expect_t model_q[$];
	logic [TAG_W-1:0] next_tag;
	logic [31:0] lcg_state;
	int errors;
	int tests_run;
	int tests_failed;
	int cycles;

	ooo_commit_top #(.ROB_DEPTH(ROB_DEPTH)) u_dut (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_unit(issue_unit),
		.issue_word(issue_word), .issue_store_data(issue_store_data),
		.issue_ready(issue_ready), .issue_tag(issue_tag), .commit_valid(commit_valid),
		.commit_tag(commit_tag), .commit_data(commit_data), .commit_addr(commit_addr),
		.commit_is_store(commit_is_store)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic logic [WORD_SIZE-1:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// opcode rules, all modulo 2^16
	function automatic logic [WORD_SIZE-1:0] alu_expect(alu_op_t op,
			logic [WORD_SIZE-1:0] a, logic [WORD_SIZE-1:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			default: return a ^ b;
		endcase
	endfunction

	function automatic issue_word_u make_alu(alu_op_t op, logic [WORD_SIZE-1:0] a,
			logic [WORD_SIZE-1:0] b);
		issue_word_u w;
		w.alu.op = op;
		w.alu.a = a;
		w.alu.b = b;
		return w;
	endfunction

	function automatic issue_word_u make_store(logic [WORD_SIZE-1:0] base,
			logic [WORD_SIZE-1:0] offset);
		issue_word_u w;
		w = '0;
		w.store.base = base;
		w.store.offset = offset;
		return w;
	endfunction

	task automatic check_word(string name, logic [WORD_SIZE-1:0] got,
			logic [WORD_SIZE-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_tag(string name, logic [TAG_W-1:0] got, logic [TAG_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// drives one issue word for one cycle and records it if the ROB takes it
	task automatic issue_one(fu_sel_t unit, issue_word_u word,
			logic [WORD_SIZE-1:0] sdata, output logic accepted);
		expect_t e;
		@(negedge clk);
		issue_valid = 1'b1;
		issue_unit = unit;
		issue_word = word;
		issue_store_data = sdata;
		accepted = issue_ready && (unit != FU_NONE);
		if (accepted) begin
			check_tag("issue_tag", issue_tag, next_tag);
			e.tag = next_tag;
			e.is_store = (unit == FU_STORE);
			if (e.is_store) begin
				e.addr = word.store.base + word.store.offset;
				e.data = sdata;
			end else begin
				e.addr = '0;
				e.data = alu_expect(word.alu.op, word.alu.a, word.alu.b);
			end
			model_q.push_back(e);
			next_tag = next_tag + 1'b1;
		end
	endtask

	task automatic wait_drain();
		@(negedge clk);
		issue_valid = 1'b0;
		while (model_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic apply_reset(int n);
		@(negedge clk);
		reset = 1'b1;
		issue_valid = 1'b0;
		model_q.delete();
		repeat (n) @(negedge clk);
		reset = 1'b0;
		next_tag = '0;
	endtask

	task automatic report_test(string name, int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - err_before);
			tests_failed++;
		end
	endtask

	// retired entries must match the model queue in issue order
	always @(posedge clk) begin : commit_monitor
		expect_t e;
		if (!reset && commit_valid) begin
			if (model_q.size() == 0) begin
				$display("commit of tag %0h with no issued entry outstanding", commit_tag);
				errors++;
			end else begin
				e = model_q.pop_front();
				check_tag("commit_tag", commit_tag, e.tag);
				check_word("commit_data", commit_data, e.data);
				check_word("commit_addr", commit_addr, e.addr);
				check_bit("commit_is_store", commit_is_store, e.is_store);
			end
		end
	end

	task automatic test_alu_ops();
		int err_before;
		logic acc;
		err_before = errors;
		for (int u = 0; u < 2; u++) begin
			for (int op = 0; op < 4; op++) begin
				issue_one(fu_sel_t'(u), make_alu(alu_op_t'(op), rand16(), rand16()), '0, acc);
				wait_drain();
			end
		end
		report_test("alu_ops", err_before);
	endtask

	task automatic test_stores();
		int err_before;
		logic acc;
		err_before = errors;
		issue_one(FU_STORE, make_store(16'h1000, 16'h0234), 16'hbeef, acc);
		wait_drain();
		// address wraps past 16'hffff
		issue_one(FU_STORE, make_store(16'hfff0, 16'h0020), 16'h1234, acc);
		wait_drain();
		issue_one(FU_STORE, make_store(rand16(), rand16()), rand16(), acc);
		issue_one(FU_STORE, make_store(rand16(), rand16()), rand16(), acc);
		wait_drain();
		report_test("stores", err_before);
	endtask

	// all three units in turn, one issue per cycle
	task automatic test_burst();
		int err_before;
		logic acc;
		err_before = errors;
		for (int i = 0; i < 68; i++) begin
			acc = 1'b0;
			while (!acc) begin
				if (i % 3 == 2) begin
					issue_one(FU_STORE, make_store(rand16(), rand16()), rand16(), acc);
				end else begin
					issue_one(fu_sel_t'(i % 3), make_alu(alu_op_t'(rand16() % 4),
						rand16(), rand16()), '0, acc);
				end
			end
		end
		wait_drain();
		report_test("burst", err_before);
	endtask

	// commit keeps pace with issue, so depth 8 never fills and tags wrap
	task automatic test_no_fill();
		int err_before;
		logic acc;
		err_before = errors;
		for (int i = 0; i < 9; i++) begin
			issue_one(fu_sel_t'(i % 2), make_alu(ALU_ADD, rand16(), rand16()), '0, acc);
			check_bit("issue_ready", issue_ready, 1'b1);
		end
		wait_drain();
		report_test("no_fill", err_before);
	endtask

	task automatic test_bad_unit();
		int err_before;
		logic acc;
		err_before = errors;
		issue_one(FU_ALU1, make_alu(ALU_XOR, rand16(), rand16()), '0, acc);
		wait_drain();
		issue_one(FU_NONE, make_alu(ALU_ADD, rand16(), rand16()), '0, acc);
		@(negedge clk);
		issue_valid = 1'b0;
		check_tag("issue_tag", issue_tag, next_tag);
		// any commit here would hit an empty model queue
		repeat (6) @(negedge clk);
		issue_one(FU_ALU0, make_alu(ALU_SUB, rand16(), rand16()), '0, acc);
		wait_drain();
		report_test("bad_unit", err_before);
	endtask

	task automatic test_mid_reset();
		int err_before;
		logic acc;
		err_before = errors;
		for (int i = 0; i < 4; i++) begin
			issue_one(FU_ALU0, make_alu(ALU_AND, rand16(), rand16()), '0, acc);
		end
		apply_reset(5);
		check_bit("commit_valid", commit_valid, 1'b0);
		check_bit("issue_ready", issue_ready, 1'b1);
		check_tag("issue_tag", issue_tag, '0);
		for (int i = 0; i < 4; i++) begin
			issue_one(fu_sel_t'(i % 3), make_store(rand16(), rand16()), rand16(), acc);
		end
		wait_drain();
		report_test("mid_reset", err_before);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_unit = FU_ALU0;
		issue_word = '0;
		issue_store_data = '0;
		next_tag = '0;
		lcg_state = 32'h5bb2;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		test_alu_ops();
		test_stores();
		test_burst();
		test_no_fill();
		test_bad_unit();
		test_mid_reset();
		repeat (4) @(negedge clk);
		if (model_q.size() != 0) begin
			$display("%0d issued entries never committed", model_q.size());
			errors++;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* ooo_commit.f */
cdb_pkg.sv
cdb_result_if.sv
issue_dispatch.sv
alu_unit.sv
store_agu.sv
cdb_writeback.sv
reorder_buffer.sv
ooo_commit_top.sv
tb_ooo_commit.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_ooo_commit -f ooo_commit.f &&
./obj_dir/Vtb_ooo_commit | tee /dev/stderr | grep -qF '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
